//--- sub_mult_abs.f
src/stream_pkg.sv
src/fixed_pkg.sv
src/beat_if.sv
src/axis_if.sv
src/frame_align.sv
src/sub_mult.sv
src/abs_sat.sv
src/sub_mult_abs.sv
test/tb_sub_mult_abs.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the sub_mult_abs testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --top-module tb_sub_mult_abs -f sub_mult_abs.f -o sim

./obj_dir/sim | tee sim.log

if grep -q "^>>> PASS$" sim.log; then
  echo "Simulation result: passed"
else
  echo "Simulation result: failed"
  exit 1
fi

//--- test/tb_sub_mult_abs.sv
`timescale 1ns/100ps

module tb_sub_mult_abs
  import stream_pkg::*;
();

  localparam int NUM_FRAMES = 19;
  // Q12 times Q12 back to Q12
  localparam int SHIFT = 12;

  logic        clk;
  logic        reset;
  logic [15:0] tdata  [3];
  logic        tvalid [3];
  logic        tlast  [3];
  logic        tready [3];
  logic [7:0]  data_tid;
  logic [15:0] m_axis_tdata;
  logic        m_axis_tvalid;
  logic        m_axis_tready;
  logic        m_axis_tlast;
  logic [7:0]  m_axis_tid;

  // Per beat: gap[27:25], last[24], tid[23:16], sample[15:0]
  logic [27:0] beat_q [3][$];
  // Per beat: last[24], tid[23:16], tdata[15:0]
  logic [24:0] exp_q [$];
  string       name_q [$];
  logic [24:0] exp_beat;
  string       exp_name;

  int seed = 66;
  // Separate stream for the output ready pattern
  int ready_seed = 66;
  int errors = 0;
  int beats_out = 0;
  int exp_total = 0;
  bit bp_on = 0;

  sub_mult_abs i_dut (
    .clk                 (clk),
    .reset               (reset),
    .s_axis_data_tdata   (tdata[CH_DATA]),
    .s_axis_data_tvalid  (tvalid[CH_DATA]),
    .s_axis_data_tready  (tready[CH_DATA]),
    .s_axis_data_tlast   (tlast[CH_DATA]),
    .s_axis_data_tid     (data_tid),
    .s_axis_grid_tdata   (tdata[CH_GRID]),
    .s_axis_grid_tvalid  (tvalid[CH_GRID]),
    .s_axis_grid_tready  (tready[CH_GRID]),
    .s_axis_grid_tlast   (tlast[CH_GRID]),
    .s_axis_scale_tdata  (tdata[CH_SCALE]),
    .s_axis_scale_tvalid (tvalid[CH_SCALE]),
    .s_axis_scale_tready (tready[CH_SCALE]),
    .s_axis_scale_tlast  (tlast[CH_SCALE]),
    .m_axis_tdata        (m_axis_tdata),
    .m_axis_tvalid       (m_axis_tvalid),
    .m_axis_tready       (m_axis_tready),
    .m_axis_tlast        (m_axis_tlast),
    .m_axis_tid          (m_axis_tid)
  );

  initial clk = 1'b0;
  always #20 clk = ~clk;

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      $display("FAIL %s: expected %0d, actual %0d", name, expected, actual);
      errors++;
    end
  endtask

  task automatic check_idle(input string name);
    check_value({name, " m_axis_tvalid"}, 32'd0, 32'(m_axis_tvalid));
    check_value({name, " data tready"}, 32'd0, 32'(tready[CH_DATA]));
    check_value({name, " grid tready"}, 32'd0, 32'(tready[CH_GRID]));
    check_value({name, " scale tready"}, 32'd0, 32'(tready[CH_SCALE]));
  endtask

  // Queue one frame per channel and its expected output frame
  task automatic add_frame(input string name, input int mode, input bit gaps);
    int len [3];
    int smp [3][8];
    int tid [8];
    int sat_d [4] = '{16000, -16000, 4000, 20000};
    int sat_g [4] = '{-16000, 16000, -4000, -12000};
    int sat_s [4] = '{12000, 12000, -16000, 16000};
    int n;
    int gap;
    int k [3];
    longint prod;
    for (int c = 0; c < 3; c++) begin
      len[c] = (mode == 2) ? 4 : 1 + ($random(seed) & 7);
    end
    if (mode == 0) begin
      len[CH_GRID]  = len[CH_DATA];
      len[CH_SCALE] = len[CH_DATA];
    end
    for (int i = 0; i < 8; i++) begin
      tid[i] = $random(seed) & 255;
      for (int c = 0; c < 3; c++) begin
        smp[c][i] = $random(seed) % 8192;
      end
      if (mode == 2 && i < 4) begin
        smp[CH_DATA][i]  = sat_d[i];
        smp[CH_GRID][i]  = sat_g[i];
        smp[CH_SCALE][i] = sat_s[i];
      end
    end
    for (int c = 0; c < 3; c++) begin
      for (int i = 0; i < len[c]; i++) begin
        gap = gaps ? ($random(seed) & 3) : 0;
        beat_q[c].push_back({3'(gap), (i == len[c] - 1), 8'(tid[i]), 16'(smp[c][i])});
      end
    end
    n = len[0];
    for (int c = 1; c < 3; c++) begin
      if (len[c] > n) n = len[c];
    end
    // Shorter frames repeat their final sample
    for (int i = 0; i < n; i++) begin
      for (int c = 0; c < 3; c++) begin
        k[c] = (i < len[c]) ? i : len[c] - 1;
      end
      prod = longint'(smp[CH_DATA][k[CH_DATA]] - smp[CH_GRID][k[CH_GRID]]) *
             longint'(smp[CH_SCALE][k[CH_SCALE]]);
      prod = prod >>> SHIFT;
      if (prod < 0) prod = -prod;
      if (prod > 65535) prod = 65535;
      exp_q.push_back({(i == n - 1), 8'(tid[k[CH_DATA]]), 16'(prod)});
      name_q.push_back(name);
      exp_total++;
    end
  endtask

  task automatic drive_channel(input chan_e c);
    logic [27:0] b;
    while (beat_q[c].size() > 0) begin
      b = beat_q[c].pop_front();
      repeat (b[27:25]) @(posedge clk);
      tdata[c] <= b[15:0];
      tlast[c] <= b[24];
      if (c == CH_DATA) data_tid <= b[23:16];
      tvalid[c] <= 1'b1;
      do @(posedge clk); while (!tready[c]);
      tvalid[c] <= 1'b0;
    end
  endtask

  task automatic run_phase(input string name, input int frames, input int mode,
                           input bit gaps);
    for (int f = 0; f < frames; f++) add_frame(name, mode, gaps);
    @(posedge clk);
    fork
      drive_channel(CH_DATA);
      drive_channel(CH_GRID);
      drive_channel(CH_SCALE);
    join
    while (exp_q.size() != 0) @(negedge clk);
    @(posedge clk);
  endtask

  always @(posedge clk) begin
    m_axis_tready <= bp_on ? (($random(ready_seed) % 2) != 0) : 1'b1;
  end

  // Compare every accepted output beat with the model
  always @(posedge clk) begin
    if (!reset && m_axis_tvalid && m_axis_tready) begin
      beats_out++;
      if (exp_q.size() == 0) begin
        $display("Output beat arrived with no expected beat left, tdata %0d", m_axis_tdata);
        errors++;
      end else begin
        exp_beat = exp_q.pop_front();
        exp_name = name_q.pop_front();
        check_value({exp_name, " tdata"}, 32'(exp_beat[15:0]), 32'(m_axis_tdata));
        check_value({exp_name, " tid"}, 32'(exp_beat[23:16]), 32'(m_axis_tid));
        check_value({exp_name, " tlast"}, 32'(exp_beat[24]), 32'(m_axis_tlast));
      end
    end
  end

  initial begin
    #(NUM_FRAMES * 8 * 20 * 40);
    $display("Timeout: the output frames did not finish in time");
    $display(">>> FAIL");
    $finish;
  end

  initial begin
    reset         = 1'b1;
    data_tid      = '0;
    m_axis_tready = 1'b0;
    for (int c = 0; c < 3; c++) begin
      tdata[c]  = '0;
      tvalid[c] = 1'b0;
      tlast[c]  = 1'b0;
    end
    @(posedge clk);
    repeat (3) begin
      @(posedge clk);
      check_idle("during_reset");
    end
    reset <= 1'b0;
    repeat (2) begin
      @(posedge clk);
      check_idle("after_reset");
    end
    run_phase("equal_len", 4, 0, 1'b0);
    run_phase("unequal_len", 6, 1, 1'b0);
    bp_on <= 1'b1;
    run_phase("backpressure", 8, 1, 1'b1);
    bp_on <= 1'b0;
    run_phase("saturation", 1, 2, 1'b0);
    check_value("beat_count", 32'(exp_total), 32'(beats_out));
    $display("Run complete: %0d errors, %0d of %0d output beats", errors, beats_out,
             exp_total);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

//--- src/sub_mult_abs.sv
`timescale 1ns/100ps

// abs((data - grid) * scale) over three aligned AXI-Stream frames
module sub_mult_abs
  import fixed_pkg::*, stream_pkg::*;
#(
  parameter int DATA_WIDTH  = DATA_WIDTH_DEF,
  parameter int DATA_FRAC   = DATA_FRAC_DEF,
  parameter int SCALE_WIDTH = SCALE_WIDTH_DEF,
  parameter int SCALE_FRAC  = SCALE_FRAC_DEF,
  parameter int RSLT_WIDTH  = RSLT_WIDTH_DEF,
  parameter int RSLT_FRAC   = RSLT_FRAC_DEF,
  parameter int ID_WIDTH    = ID_WIDTH_DEF
) (
  input  logic                   clk,
  input  logic                   reset,

  input  logic [DATA_WIDTH-1:0]  s_axis_data_tdata,
  input  logic                   s_axis_data_tvalid,
  output logic                   s_axis_data_tready,
  input  logic                   s_axis_data_tlast,
  input  logic [ID_WIDTH-1:0]    s_axis_data_tid,

  input  logic [DATA_WIDTH-1:0]  s_axis_grid_tdata,
  input  logic                   s_axis_grid_tvalid,
  output logic                   s_axis_grid_tready,
  input  logic                   s_axis_grid_tlast,

  input  logic [SCALE_WIDTH-1:0] s_axis_scale_tdata,
  input  logic                   s_axis_scale_tvalid,
  output logic                   s_axis_scale_tready,
  input  logic                   s_axis_scale_tlast,

  output logic [RSLT_WIDTH-1:0]  m_axis_tdata,
  output logic                   m_axis_tvalid,
  input  logic                   m_axis_tready,
  output logic                   m_axis_tlast,
  output logic [ID_WIDTH-1:0]    m_axis_tid
);

  beat_if #(
    .DATA_WIDTH  (DATA_WIDTH),
    .SCALE_WIDTH (SCALE_WIDTH),
    .ID_WIDTH    (ID_WIDTH)
  ) beat ();

  // Shifted product with two guard bits for sign and overflow
  axis_if #(
    .WIDTH    (RSLT_WIDTH + 2),
    .ID_WIDTH (ID_WIDTH)
  ) prod ();

  frame_align #(
    .DATA_WIDTH  (DATA_WIDTH),
    .SCALE_WIDTH (SCALE_WIDTH),
    .ID_WIDTH    (ID_WIDTH)
  ) i_frame_align (
    .clk            (clk),
    .reset          (reset),
    .s_data_tdata   (s_axis_data_tdata),
    .s_grid_tdata   (s_axis_grid_tdata),
    .s_scale_tdata  (s_axis_scale_tdata),
    .s_data_tvalid  (s_axis_data_tvalid),
    .s_grid_tvalid  (s_axis_grid_tvalid),
    .s_scale_tvalid (s_axis_scale_tvalid),
    .s_data_tlast   (s_axis_data_tlast),
    .s_grid_tlast   (s_axis_grid_tlast),
    .s_scale_tlast  (s_axis_scale_tlast),
    .s_data_tid     (s_axis_data_tid),
    .s_data_tready  (s_axis_data_tready),
    .s_grid_tready  (s_axis_grid_tready),
    .s_scale_tready (s_axis_scale_tready),
    .out            (beat.source)
  );

  sub_mult #(
    .DATA_WIDTH  (DATA_WIDTH),
    .DATA_FRAC   (DATA_FRAC),
    .SCALE_WIDTH (SCALE_WIDTH),
    .SCALE_FRAC  (SCALE_FRAC),
    .RSLT_WIDTH  (RSLT_WIDTH),
    .RSLT_FRAC   (RSLT_FRAC),
    .ID_WIDTH    (ID_WIDTH)
  ) i_sub_mult (
    .clk   (clk),
    .reset (reset),
    .in    (beat.sink),
    .out   (prod.source)
  );

  abs_sat #(
    .RSLT_WIDTH (RSLT_WIDTH),
    .ID_WIDTH   (ID_WIDTH)
  ) i_abs_sat (
    .clk           (clk),
    .reset         (reset),
    .in            (prod.sink),
    .m_axis_tdata  (m_axis_tdata),
    .m_axis_tvalid (m_axis_tvalid),
    .m_axis_tlast  (m_axis_tlast),
    .m_axis_tid    (m_axis_tid),
    .m_axis_tready (m_axis_tready)
  );

endmodule

//--- src/abs_sat.sv
`timescale 1ns/100ps

module abs_sat
  import fixed_pkg::*, stream_pkg::*;
#(
  parameter int RSLT_WIDTH = RSLT_WIDTH_DEF,
  parameter int ID_WIDTH   = ID_WIDTH_DEF
) (
  input  logic                  clk,
  input  logic                  reset,
  axis_if.sink                  in,
  output logic [RSLT_WIDTH-1:0] m_axis_tdata,
  output logic                  m_axis_tvalid,
  output logic                  m_axis_tlast,
  output logic [ID_WIDTH-1:0]   m_axis_tid,
  input  logic                  m_axis_tready
);

  logic signed [RSLT_WIDTH+1:0] val;
  logic [RSLT_WIDTH+1:0]        mag;
  logic                         over;
  logic [RSLT_WIDTH-1:0]        clipped;

  assign val = in.tdata;
  // Most negative input still maps to the right unsigned magnitude
  assign mag = val[RSLT_WIDTH+1] ? -val : val;
  // Anything in the two guard bits is past the unsigned range
  assign over    = |mag[RSLT_WIDTH+1:RSLT_WIDTH];
  assign clipped = over ? '1 : mag[RSLT_WIDTH-1:0];

  assign in.tready = ~m_axis_tvalid | m_axis_tready;

  always_ff @(posedge clk) begin
    if (reset) begin
      m_axis_tvalid <= 1'b0;
    end else if (in.tready) begin
      m_axis_tvalid <= in.tvalid;
    end
  end

  always_ff @(posedge clk) begin
    if (in.tvalid && in.tready) begin
      m_axis_tdata <= clipped;
      m_axis_tlast <= in.tlast;
      m_axis_tid   <= in.tid;
    end
  end

endmodule

//--- src/sub_mult.sv
`timescale 1ns/100ps

module sub_mult
  import fixed_pkg::*, stream_pkg::*;
#(
  parameter int DATA_WIDTH  = DATA_WIDTH_DEF,
  parameter int DATA_FRAC   = DATA_FRAC_DEF,
  parameter int SCALE_WIDTH = SCALE_WIDTH_DEF,
  parameter int SCALE_FRAC  = SCALE_FRAC_DEF,
  parameter int RSLT_WIDTH  = RSLT_WIDTH_DEF,
  parameter int RSLT_FRAC   = RSLT_FRAC_DEF,
  parameter int ID_WIDTH    = ID_WIDTH_DEF
) (
  input  logic   clk,
  input  logic   reset,
  beat_if.sink   in,
  axis_if.source out
);

  localparam int DIFF_W = DATA_WIDTH + 1;
  localparam int PROD_W = DIFF_W + SCALE_WIDTH;
  localparam int OUT_W  = RSLT_WIDTH + 2;
  // Product carries DATA_FRAC + SCALE_FRAC fraction bits
  localparam int SHIFT  = DATA_FRAC + SCALE_FRAC - RSLT_FRAC;

  // Stage 1
  logic                          s1_valid;
  logic                          s1_ready;
  logic signed [DIFF_W-1:0]      s1_diff;
  logic signed [SCALE_WIDTH-1:0] s1_scale;
  logic                          s1_last;
  logic [ID_WIDTH-1:0]           s1_id;

  // Stage 2
  logic                          s2_valid;
  logic                          s2_ready;
  logic signed [OUT_W-1:0]       s2_data;
  logic                          s2_last;
  logic [ID_WIDTH-1:0]           s2_id;

  logic signed [PROD_W-1:0]      product;
  logic signed [PROD_W-1:0]      shifted;

  assign s2_ready = ~s2_valid | out.tready;
  assign s1_ready = ~s1_valid | s2_ready;
  assign in.ready = s1_ready;

  always_ff @(posedge clk) begin
    if (reset) begin
      s1_valid <= 1'b0;
    end else if (s1_ready) begin
      s1_valid <= in.valid;
    end
  end

  // Difference is one bit wider so it cannot overflow
  always_ff @(posedge clk) begin
    if (in.valid && s1_ready) begin
      s1_diff  <= DIFF_W'(in.data) - DIFF_W'(in.grid);
      s1_scale <= in.scale;
      s1_last  <= in.last;
      s1_id    <= in.id;
    end
  end

  assign product = s1_diff * s1_scale;
  // Arithmetic shift, floors toward minus infinity
  assign shifted = product >>> SHIFT;

  always_ff @(posedge clk) begin
    if (reset) begin
      s2_valid <= 1'b0;
    end else if (s2_ready) begin
      s2_valid <= s1_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (s1_valid && s2_ready) begin
      s2_data <= OUT_W'(shifted);
      s2_last <= s1_last;
      s2_id   <= s1_id;
    end
  end

  assign out.tvalid = s2_valid;
  assign out.tdata  = s2_data;
  assign out.tlast  = s2_last;
  assign out.tid    = s2_id;

endmodule

//--- src/frame_align.sv
`timescale 1ns/100ps

module frame_align
  import stream_pkg::*;
#(
  parameter int DATA_WIDTH  = 16,
  parameter int SCALE_WIDTH = 16,
  parameter int ID_WIDTH    = 8
) (
  input  logic                   clk,
  input  logic                   reset,
  input  logic [DATA_WIDTH-1:0]  s_data_tdata,
  input  logic [DATA_WIDTH-1:0]  s_grid_tdata,
  input  logic [SCALE_WIDTH-1:0] s_scale_tdata,
  input  logic                   s_data_tvalid,
  input  logic                   s_grid_tvalid,
  input  logic                   s_scale_tvalid,
  input  logic                   s_data_tlast,
  input  logic                   s_grid_tlast,
  input  logic                   s_scale_tlast,
  input  logic [ID_WIDTH-1:0]    s_data_tid,
  output logic                   s_data_tready,
  output logic                   s_grid_tready,
  output logic                   s_scale_tready,
  beat_if.source                 out
);

  localparam int HOLD_W = (DATA_WIDTH > SCALE_WIDTH) ? DATA_WIDTH : SCALE_WIDTH;

  logic [NUM_CH-1:0] ended;
  logic [NUM_CH-1:0] vld;
  logic [NUM_CH-1:0] in_last;
  logic [NUM_CH-1:0] rdy;
  logic              xfer;

  logic [HOLD_W-1:0]   in_smp   [NUM_CH];
  logic [HOLD_W-1:0]   held     [NUM_CH];
  logic [HOLD_W-1:0]   beat_smp [NUM_CH];
  logic [ID_WIDTH-1:0] held_id;

  // Gather the channels into vectors indexed by chan_e
  assign vld[CH_DATA]      = s_data_tvalid;
  assign vld[CH_GRID]      = s_grid_tvalid;
  assign vld[CH_SCALE]     = s_scale_tvalid;
  assign in_last[CH_DATA]  = s_data_tlast;
  assign in_last[CH_GRID]  = s_grid_tlast;
  assign in_last[CH_SCALE] = s_scale_tlast;
  assign in_smp[CH_DATA]   = HOLD_W'(s_data_tdata);
  assign in_smp[CH_GRID]   = HOLD_W'(s_grid_tdata);
  assign in_smp[CH_SCALE]  = HOLD_W'(s_scale_tdata);

  // Ended channels stand in with their final sample
  always_comb begin
    for (int c = 0; c < NUM_CH; c++) begin
      beat_smp[c] = ended[c] ? held[c] : in_smp[c];
    end
  end

  assign out.valid = &(vld | ended);
  assign out.last  = &(in_last | ended);
  assign out.data  = beat_smp[CH_DATA][DATA_WIDTH-1:0];
  assign out.grid  = beat_smp[CH_GRID][DATA_WIDTH-1:0];
  assign out.scale = beat_smp[CH_SCALE][SCALE_WIDTH-1:0];
  assign out.id    = ended[CH_DATA] ? held_id : s_data_tid;

  assign xfer = out.valid & out.ready;
  // Only live channels are consumed
  assign rdy  = ~ended & {NUM_CH{xfer}};

  assign s_data_tready  = rdy[CH_DATA];
  assign s_grid_tready  = rdy[CH_GRID];
  assign s_scale_tready = rdy[CH_SCALE];

  always_ff @(posedge clk) begin
    if (reset) begin
      ended <= '0;
    end else if (xfer) begin
      // Whole output frame done once every channel has seen tlast
      if (out.last) begin
        ended <= '0;
      end else begin
        ended <= ended | in_last;
      end
    end
  end

  // Keep the most recent accepted sample of each channel
  always_ff @(posedge clk) begin
    for (int c = 0; c < NUM_CH; c++) begin
      if (rdy[c]) begin
        held[c] <= in_smp[c];
      end
    end
    if (rdy[CH_DATA]) begin
      held_id <= s_data_tid;
    end
  end

endmodule

//--- src/axis_if.sv
`timescale 1ns/100ps

// Single-word stream with frame end and id
interface axis_if
  import fixed_pkg::*, stream_pkg::*;
#(
  parameter int WIDTH    = RSLT_WIDTH_DEF + 2,
  parameter int ID_WIDTH = ID_WIDTH_DEF
);

  logic [WIDTH-1:0]    tdata;
  logic                tvalid;
  logic                tready;
  logic                tlast;
  logic [ID_WIDTH-1:0] tid;

  modport source (output tdata, tvalid, tlast, tid, input tready);

  modport sink (input tdata, tvalid, tlast, tid, output tready);

endinterface

//--- src/beat_if.sv
`timescale 1ns/100ps

// One aligned beat of data, grid and scale
interface beat_if
  import fixed_pkg::*, stream_pkg::*;
#(
  parameter int DATA_WIDTH  = DATA_WIDTH_DEF,
  parameter int SCALE_WIDTH = SCALE_WIDTH_DEF,
  parameter int ID_WIDTH    = ID_WIDTH_DEF
);

  logic signed [DATA_WIDTH-1:0]  data;
  logic signed [DATA_WIDTH-1:0]  grid;
  logic signed [SCALE_WIDTH-1:0] scale;
  logic                          last;
  logic [ID_WIDTH-1:0]           id;
  logic                          valid;
  logic                          ready;

  modport source (
    output data, grid, scale, last, id, valid,
    input  ready
  );

  modport sink (
    input  data, grid, scale, last, id, valid,
    output ready
  );

endinterface

//--- src/fixed_pkg.sv
package fixed_pkg;

  // Data and grid samples, signed
  localparam int DATA_WIDTH_DEF = 16;
  localparam int DATA_FRAC_DEF  = 12;

  // Scale factor, signed
  localparam int SCALE_WIDTH_DEF = 16;
  localparam int SCALE_FRAC_DEF  = 12;

  // Result magnitude, unsigned
  localparam int RSLT_WIDTH_DEF = 16;
  localparam int RSLT_FRAC_DEF  = 12;

endpackage

//--- src/stream_pkg.sv
package stream_pkg;

  // Input channels of the three-way join
  typedef enum logic [1:0] {
    CH_DATA  = 2'd0,
    CH_GRID  = 2'd1,
    CH_SCALE = 2'd2
  } chan_e;

  // Number of joined input streams
  localparam int NUM_CH = 3;

  // Default tid width, carried from the data stream only
  localparam int ID_WIDTH_DEF = 8;

endpackage
